// ==== common/motor_pkg.sv ====
/*
 * Motion and driver-link types. A bus write word is seen either as a motion
 * command or as an SPI frame, through cmd_word_u. Position is signed.
 */
`default_nettype none

package motor_pkg;

  // each half period of sck lasts this many clocks
  localparam int unsigned SPI_DIV = 2;

  // signed step position count
  localparam int POS_W = 32;

  // motion register layout
  typedef struct packed {
    logic        enable;
    // 0 counts up, 1 counts down
    logic        dir;
    logic [13:0] reserved;
    // step half period in clocks, 0 stops stepping
    logic [15:0] half_period;
  } motion_cmd_t;

  // frame for the driver chip, sent msb first
  typedef struct packed {
    logic [7:0]  reg_addr;
    logic [23:0] reg_data;
  } spi_frame_t;

  // two views of one write word
  typedef union packed {
    motion_cmd_t motion;
    spi_frame_t  frame;
  } cmd_word_u;

endpackage

`default_nettype wire

// ==== common/stepper_bus_pkg.sv ====
/*
 * Bus side of the stepper IO block. All accesses are full 32-bit words on a
 * 3-bit word address, with no byte enables. Addresses 5 to 7 are unmapped.
 */
`default_nettype none

package stepper_bus_pkg;

  // word address width
  localparam int ADDR_W = 3;

  // register map, word offsets
  localparam logic [ADDR_W-1:0] REG_LED      = 3'd0;
  localparam logic [ADDR_W-1:0] REG_MOTION   = 3'd1;
  // read only
  localparam logic [ADDR_W-1:0] REG_POSITION = 3'd2;
  // write starts a transfer, read gives last reply
  localparam logic [ADDR_W-1:0] REG_SPI      = 3'd3;
  // read only, bit 0 spi busy, bit 1 motion enable
  localparam logic [ADDR_W-1:0] REG_STATUS   = 3'd4;

  // request as seen on the bus, 36 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [31:0]       wdata;
  } io_req_t;

  // response, rdata is zero after writes and errors
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } io_rsp_t;

  // read selector handed from decode to readback
  typedef enum logic [2:0] {
    SEL_LED      = 3'd0,
    SEL_MOTION   = 3'd1,
    SEL_POSITION = 3'd2,
    SEL_SPI      = 3'd3,
    SEL_STATUS   = 3'd4,
    SEL_NONE     = 3'd7
  } reg_sel_t;

endpackage

`default_nettype wire

// ==== dv/stepper_io_sva.sv ====
/*
 * Handshake and idle-line assertions, bound into stepper_io.
 * All checks are off while rst is high.
 */
`default_nettype none

module stepper_io_sva (
  input wire logic                     clk_in,
  input wire logic                     rst,
  input wire logic                     req_valid,
  input wire stepper_bus_pkg::io_req_t req,
  input wire logic                     req_ready,
  input wire logic                     rsp_valid,
  input wire stepper_bus_pkg::io_rsp_t rsp,
  input wire logic                     rsp_ready,
  input wire logic                     spi_busy,
  input wire logic                     sck,
  input wire logic                     cs_n
);

  // held response keeps valid and payload
  rsp_hold: assert property (@(posedge clk_in) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else $error("rsp changed while waiting for rsp_ready");

  // spi write against a busy link is not taken
  spi_stall: assert property (@(posedge clk_in) disable iff (rst)
    req_valid && req.write && (req.addr == stepper_bus_pkg::REG_SPI) && spi_busy
    |-> !req_ready)
    else $error("req_ready high during a stalled SPI write");

  // mode 3 idle lines
  spi_idle: assert property (@(posedge clk_in) disable iff (rst)
    !spi_busy |-> cs_n && sck)
    else $error("cs_n or sck low while the SPI link is idle");

endmodule

`default_nettype wire

// ==== dv/stepper_io_tb.sv ====
/*
 * Directed testbench for stepper_io with an SPI mode 3 slave model.
 * One request is in flight at a time, and each response is taken before the
 * next request. Random holds and replies come from a fixed seed.
 */
`default_nettype none

module stepper_io_tb;

  // worst case cycles per piece of the run
  localparam int BUS_CYC  = 12;
  localparam int RUN_CYC  = 60;
  localparam int SPI_CYC  = 2 * motor_pkg::SPI_DIV * 34;
  localparam int LIMIT    = 10 + 4 * BUS_CYC + 2 * (RUN_CYC + 3 * BUS_CYC) +
                            (SPI_CYC + 4 * BUS_CYC) + (2 * SPI_CYC + 8 * BUS_CYC) + 200;

  logic                     clk_in;
  logic                     rst;
  logic                     req_valid;
  stepper_bus_pkg::io_req_t req;
  logic                     req_ready;
  logic                     rsp_valid;
  stepper_bus_pkg::io_rsp_t rsp;
  logic                     rsp_ready;
  logic [7:0]               led;
  logic                     step;
  logic                     dir_out;
  logic                     sck;
  logic                     mosi;
  logic                     cs_n;
  logic                     miso;

  int checks = 0;
  int errors = 0;
  int tests  = 0;
  int cycles = 0;
  int rises  = 0;
  logic signed [motor_pkg::POS_W-1:0] exp_pos = '0;

  // slave model state
  logic [31:0] spi_reply;
  logic [31:0] spi_shift;
  int          spi_bits = 0;
  logic [31:0] frames[$];
  logic [31:0] replies[$];

  stepper_io DUT (
    .clk_in    (clk_in),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .rsp_ready (rsp_ready),
    .led       (led),
    .step      (step),
    .dir_out   (dir_out),
    .sck       (sck),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .miso      (miso)
  );

  bind stepper_io stepper_io_sva u_sva (
    .clk_in    (clk_in),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .rsp_ready (rsp_ready),
    .spi_busy  (spi_busy),
    .sck       (sck),
    .cs_n      (cs_n)
  );

  always #20 clk_in = ~clk_in;

  // run limit
  always @(posedge clk_in) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("run stopped by timeout after %0d cycles", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  // step rises seen at the port
  always @(posedge step) rises++;

  // slave: new reply per frame, msb ready before the first rise
  always @(negedge cs_n) begin
    spi_reply = $urandom;
    spi_bits  = 0;
    miso <= spi_reply[31];
  end

  always @(posedge sck) begin
    if (!cs_n) begin
      spi_shift = {spi_shift[30:0], mosi};
      spi_bits++;
    end
  end

  // next reply bit on each fall
  always @(negedge sck) begin
    if (!cs_n && spi_bits < 32) begin
      miso <= spi_reply[31 - spi_bits];
    end
  end

  always @(posedge cs_n) begin
    if (spi_bits == 32) begin
      frames.push_back(spi_shift);
      replies.push_back(spi_reply);
    end
  end

  function automatic stepper_bus_pkg::io_rsp_t make_rsp(input logic [31:0] rdata,
                                                        input logic err);
    stepper_bus_pkg::io_rsp_t r;
    r.rdata = rdata;
    r.err   = err;
    return r;
  endfunction

  task automatic check_rsp(input string name, input stepper_bus_pkg::io_rsp_t got,
                           input stepper_bus_pkg::io_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error t=%0t %s got rdata %h err %b, expected rdata %h err %b",
               $time, name, got.rdata, got.err, exp.rdata, exp.err);
    end
  endtask

  task automatic check_pos(input string name, input logic signed [motor_pkg::POS_W-1:0] got,
                           input logic signed [motor_pkg::POS_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error t=%0t %s got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_frame(input string name, input motor_pkg::spi_frame_t got,
                             input motor_pkg::spi_frame_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error t=%0t %s got %h_%h, expected %h_%h", $time, name,
               got.reg_addr, got.reg_data, exp.reg_addr, exp.reg_data);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error t=%0t %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_led(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error t=%0t %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_fail(input string what);
    errors++;
    $display("t=%0t %s", $time, what);
  endtask

  // one request and its response, hold = cycles of rsp_ready low
  task automatic bus_access(input logic [stepper_bus_pkg::ADDR_W-1:0] addr, input logic wr,
                            input logic [31:0] wdata, input int hold,
                            output stepper_bus_pkg::io_rsp_t r, output int waits);
    stepper_bus_pkg::io_req_t q;
    q.addr  = addr;
    q.write = wr;
    q.wdata = wdata;
    waits   = 0;
    @(posedge clk_in);
    req_valid <= 1'b1;
    req       <= q;
    @(negedge clk_in);
    while (!req_ready) begin
      waits++;
      @(negedge clk_in);
    end
    // handshake on this edge
    @(posedge clk_in);
    req_valid <= 1'b0;
    @(negedge clk_in);
    if (!rsp_valid) begin
      report_fail("no response one cycle after the request was accepted");
    end
    r = rsp;
    repeat (hold) begin
      @(negedge clk_in);
      if (!rsp_valid || rsp !== r) begin
        report_fail("response changed while held under back-pressure");
      end
    end
    @(posedge clk_in);
    rsp_ready <= 1'b1;
    @(posedge clk_in);
    rsp_ready <= 1'b0;
  endtask

  task automatic write_reg(input logic [stepper_bus_pkg::ADDR_W-1:0] addr,
                           input logic [31:0] data);
    stepper_bus_pkg::io_rsp_t r;
    int waits;
    bus_access(addr, 1'b1, data, $urandom_range(0, 3), r, waits);
    check_rsp("write rsp", r, make_rsp(32'd0, 1'b0));
  endtask

  task automatic read_reg(input logic [stepper_bus_pkg::ADDR_W-1:0] addr,
                          output stepper_bus_pkg::io_rsp_t r);
    int waits;
    bus_access(addr, 1'b0, 32'd0, $urandom_range(0, 3), r, waits);
  endtask

  task automatic wait_frames(input int n);
    while (frames.size() < n) @(negedge clk_in);
  endtask

  task automatic end_test(input string name, input int e0);
    tests++;
    $display("test %-8s %s", name, (errors == e0) ? "ok" : "failed");
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    @(negedge clk_in);
    check_led("led", led, 8'd0);
    check_bit("step", step, 1'b0);
    check_bit("dir_out", dir_out, 1'b0);
    check_bit("cs_n", cs_n, 1'b1);
    check_bit("sck", sck, 1'b1);
    check_bit("rsp_valid", rsp_valid, 1'b0);
    check_bit("req_ready", req_ready, 1'b1);
    end_test("reset", e0);
  endtask

  task automatic test_led();
    stepper_bus_pkg::io_rsp_t r;
    logic [7:0] val;
    int waits;
    int e0;
    e0  = errors;
    val = 8'($urandom_range(1, 255));
    write_reg(stepper_bus_pkg::REG_LED, {24'hABCDEF, val});
    // long hold to exercise back-pressure
    bus_access(stepper_bus_pkg::REG_LED, 1'b0, 32'd0, 5, r, waits);
    check_rsp("led rsp", r, make_rsp({24'd0, val}, 1'b0));
    check_led("led", led, val);
    end_test("led", e0);
  endtask

  task automatic run_motion(input logic dir);
    motor_pkg::motion_cmd_t mc;
    stepper_bus_pkg::io_rsp_t r;
    mc             = '0;
    mc.enable      = 1'b1;
    mc.dir         = dir;
    mc.half_period = 16'($urandom_range(1, 8));
    rises          = 0;
    write_reg(stepper_bus_pkg::REG_MOTION, mc);
    repeat (RUN_CYC) @(posedge clk_in);
    mc.enable = 1'b0;
    write_reg(stepper_bus_pkg::REG_MOTION, mc);
    if (rises == 0) begin
      report_fail("no step pulses seen while the motor was enabled");
    end
    exp_pos = dir ? exp_pos - rises : exp_pos + rises;
    @(negedge clk_in);
    check_bit("step", step, 1'b0);
    check_bit("dir_out", dir_out, dir);
    read_reg(stepper_bus_pkg::REG_POSITION, r);
    check_bit("position err", r.err, 1'b0);
    check_pos("position", r.rdata, exp_pos);
  endtask

  task automatic test_motion();
    int e0;
    e0 = errors;
    run_motion(1'b0);
    run_motion(1'b1);
    end_test("motion", e0);
  endtask

  task automatic test_spi();
    stepper_bus_pkg::io_rsp_t r;
    logic [31:0] w;
    int base;
    int e0;
    e0   = errors;
    base = frames.size();
    w    = $urandom;
    write_reg(stepper_bus_pkg::REG_SPI, w);
    wait_frames(base + 1);
    check_frame("mosi frame", frames[base], w);
    read_reg(stepper_bus_pkg::REG_SPI, r);
    check_rsp("spi rx rsp", r, make_rsp(replies[base], 1'b0));
    // motor is off, link is idle
    read_reg(stepper_bus_pkg::REG_STATUS, r);
    check_rsp("status rsp", r, make_rsp(32'd0, 1'b0));
    end_test("spi", e0);
  endtask

  task automatic test_errors();
    stepper_bus_pkg::io_rsp_t r;
    logic [31:0] w1;
    logic [31:0] w2;
    int waits;
    int base;
    int e0;
    e0 = errors;
    for (int a = 5; a < 8; a++) begin
      read_reg(3'(a), r);
      check_rsp("unmapped rsp", r, make_rsp(32'd0, 1'b1));
    end
    bus_access(stepper_bus_pkg::REG_POSITION, 1'b1, 32'h1234, 0, r, waits);
    check_rsp("ro write rsp", r, make_rsp(32'd0, 1'b1));
    // second frame must wait for the link
    base = frames.size();
    w1   = $urandom;
    w2   = $urandom;
    write_reg(stepper_bus_pkg::REG_SPI, w1);
    bus_access(stepper_bus_pkg::REG_SPI, 1'b1, w2, 0, r, waits);
    if (waits == 0) begin
      report_fail("second SPI write was accepted without a stall");
    end
    if (frames.size() != base + 1) begin
      report_fail("second SPI write was accepted before the first transfer ended");
    end
    check_rsp("spi write rsp", r, make_rsp(32'd0, 1'b0));
    wait_frames(base + 2);
    check_frame("first frame", frames[base], w1);
    check_frame("second frame", frames[base + 1], w2);
    end_test("errors", e0);
  endtask

  initial begin
    void'($urandom(85297));
    clk_in    = 1'b0;
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    miso      = 1'b1;
    repeat (10) @(posedge clk_in);
    rst <= 1'b0;
    test_reset();
    test_led();
    test_motion();
    test_spi();
    test_errors();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/stepper_bus_pkg.sv
common/motor_pkg.sv
src/io_decode.sv
motion/step_generator.sv
motion/driver_spi.sv
src/io_readback.sv
src/stepper_io.sv
dv/stepper_io_sva.sv
dv/stepper_io_tb.sv

// ==== motion/driver_spi.sv ====
/*
 * SPI master for the driver chip, mode 3, one 32-bit frame per start.
 * A start is ignored while busy. The reply is updated only when a frame ends.
 */
`default_nettype none

module driver_spi (
  input  wire logic                 clk_in,
  input  wire logic                 rst,
  input  wire logic                 spi_start,
  input  wire motor_pkg::cmd_word_u cmd,
  input  wire logic                 miso,
  output logic                      sck,
  output logic                      mosi,
  output logic                      cs_n,
  output logic                      spi_busy,
  output logic [31:0]               spi_rx
);

  logic [7:0]  div_cnt;
  logic [5:0]  bit_cnt;
  logic [31:0] tx_shift;
  logic [31:0] rx_shift;
  logic        tick;

  // end of one sck half period
  assign tick = div_cnt == 8'(motor_pkg::SPI_DIV - 1);

  // msb already on the line before the first fall
  assign mosi = tx_shift[31];

  always_ff @(posedge clk_in) begin
    if (rst) begin
      sck      <= 1'b1;
      cs_n     <= 1'b1;
      spi_busy <= 1'b0;
      div_cnt  <= 8'd0;
      bit_cnt  <= 6'd0;
      tx_shift <= 32'd0;
      spi_rx   <= 32'd0;
    end else if (!spi_busy) begin
      if (spi_start) begin
        cs_n     <= 1'b0;
        spi_busy <= 1'b1;
        div_cnt  <= 8'd0;
        bit_cnt  <= 6'd0;
        tx_shift <= cmd.frame;
      end
    end else if (!tick) begin
      div_cnt <= div_cnt + 8'd1;
    end else begin
      div_cnt <= 8'd0;
      if (sck) begin
        if (bit_cnt == 6'd32) begin
          // all bits in, release the chip with sck high
          cs_n     <= 1'b1;
          spi_busy <= 1'b0;
          spi_rx   <= rx_shift;
        end else begin
          sck <= 1'b0;
          // next bit out on the falling edge
          if (bit_cnt != 6'd0) begin
            tx_shift <= {tx_shift[30:0], 1'b0};
          end
        end
      end else begin
        sck     <= 1'b1;
        bit_cnt <= bit_cnt + 6'd1;
      end
    end
  end

  // sample miso as sck rises
  always_ff @(posedge clk_in) begin
    if (spi_busy && tick && !sck) begin
      rx_shift <= {rx_shift[30:0], miso};
    end
  end

endmodule

`default_nettype wire

// ==== motion/step_generator.sv ====
/*
 * Step/direction generator. Step is high and low for half_period clocks each
 * while enabled. Any write to the motion register restarts the low phase.
 */
`default_nettype none

module step_generator (
  input  wire logic                                 clk_in,
  input  wire logic                                 rst,
  input  wire logic                                 motion_we,
  input  wire motor_pkg::cmd_word_u                 cmd,
  output motor_pkg::motion_cmd_t                    motion_cmd,
  output logic                                      step,
  output logic                                      dir_out,
  output logic signed [motor_pkg::POS_W-1:0]        position
);

  logic [15:0]                        half_cnt;
  logic                               step_q;
  logic                               run;
  logic                               half_done;
  logic signed [motor_pkg::POS_W-1:0] pos_delta;

  // zero half period means stopped even when enabled
  assign run       = motion_cmd.enable && (motion_cmd.half_period != 16'd0);
  assign half_done = half_cnt == (motion_cmd.half_period - 16'd1);

  // +1 up, -1 down
  assign pos_delta = motion_cmd.dir ? '1 : {{(motor_pkg::POS_W-1){1'b0}}, 1'b1};

  always_ff @(posedge clk_in) begin
    if (rst) begin
      motion_cmd <= '0;
      half_cnt   <= 16'd0;
      step_q     <= 1'b0;
      position   <= '0;
    end else if (motion_we) begin
      // new command, step drops on this edge
      motion_cmd <= cmd.motion;
      half_cnt   <= 16'd0;
      step_q     <= 1'b0;
    end else if (!run) begin
      half_cnt <= 16'd0;
      step_q   <= 1'b0;
    end else if (half_done) begin
      half_cnt <= 16'd0;
      step_q   <= !step_q;
      // count on the rising edge only
      if (!step_q) begin
        position <= position + pos_delta;
      end
    end else begin
      half_cnt <= half_cnt + 16'd1;
    end
  end

  assign step    = step_q;
  assign dir_out = motion_cmd.dir;

endmodule

`default_nettype wire

// ==== src/io_decode.sv ====
/*
 * Accepts one request per cycle. Stalls while a response is held, or while a
 * REG_SPI write meets a busy link. Write strobes fire only for legal writes.
 */
`default_nettype none

module io_decode (
  input  wire logic                      clk_in,
  input  wire logic                      rst,
  input  wire logic                      req_valid,
  input  wire stepper_bus_pkg::io_req_t  req,
  output logic                           req_ready,
  input  wire logic                      rsp_full,
  input  wire logic                      spi_busy,
  output logic [7:0]                     led,
  output logic                           motion_we,
  output logic                           spi_start,
  output motor_pkg::cmd_word_u           cmd,
  output logic                           acc_valid,
  output stepper_bus_pkg::reg_sel_t      acc_sel,
  output logic                           acc_write,
  output logic                           acc_err
);

  logic spi_stall;
  logic addr_ok;
  logic read_only;
  logic wr_ok;

  // hold off a second frame until the link is free
  assign spi_stall = req.write && (req.addr == stepper_bus_pkg::REG_SPI) && spi_busy;
  assign req_ready = !rsp_full && !spi_stall;
  assign acc_valid = req_valid && req_ready;

  // map check
  assign addr_ok   = req.addr <= stepper_bus_pkg::REG_STATUS;
  assign read_only = (req.addr == stepper_bus_pkg::REG_POSITION) ||
                     (req.addr == stepper_bus_pkg::REG_STATUS);
  assign acc_err   = !addr_ok || (req.write && read_only);
  assign acc_write = req.write;

  always_comb begin
    case (req.addr)
      stepper_bus_pkg::REG_LED:      acc_sel = stepper_bus_pkg::SEL_LED;
      stepper_bus_pkg::REG_MOTION:   acc_sel = stepper_bus_pkg::SEL_MOTION;
      stepper_bus_pkg::REG_POSITION: acc_sel = stepper_bus_pkg::SEL_POSITION;
      stepper_bus_pkg::REG_SPI:      acc_sel = stepper_bus_pkg::SEL_SPI;
      stepper_bus_pkg::REG_STATUS:   acc_sel = stepper_bus_pkg::SEL_STATUS;
      default:                       acc_sel = stepper_bus_pkg::SEL_NONE;
    endcase
  end

  // strobes land on the accepting edge
  assign wr_ok     = acc_valid && req.write && !acc_err;
  assign motion_we = wr_ok && (req.addr == stepper_bus_pkg::REG_MOTION);
  assign spi_start = wr_ok && (req.addr == stepper_bus_pkg::REG_SPI);
  assign cmd       = req.wdata;

  // led register, low byte of the word
  always_ff @(posedge clk_in) begin
    if (rst) begin
      led <= 8'd0;
    end else if (wr_ok && (req.addr == stepper_bus_pkg::REG_LED)) begin
      led <= req.wdata[7:0];
    end
  end

endmodule

`default_nettype wire

// ==== src/io_readback.sv ====
/*
 * Response register. Register values are sampled on the accepting edge.
 * Writes and errors answer with rdata zero. A new access only arrives once
 * the previous response is taken.
 */
`default_nettype none

module io_readback (
  input  wire logic                                 clk_in,
  input  wire logic                                 rst,
  input  wire logic                                 acc_valid,
  input  wire stepper_bus_pkg::reg_sel_t            acc_sel,
  input  wire logic                                 acc_write,
  input  wire logic                                 acc_err,
  input  wire logic [7:0]                           led,
  input  wire motor_pkg::motion_cmd_t               motion_cmd,
  input  wire logic signed [motor_pkg::POS_W-1:0]   position,
  input  wire logic                                 spi_busy,
  input  wire logic [31:0]                          spi_rx,
  output logic                                      rsp_valid,
  output stepper_bus_pkg::io_rsp_t                  rsp,
  input  wire logic                                 rsp_ready,
  output logic                                      rsp_full
);

  logic [31:0] rd_mux;

  always_comb begin
    case (acc_sel)
      stepper_bus_pkg::SEL_LED:      rd_mux = {24'd0, led};
      stepper_bus_pkg::SEL_MOTION:   rd_mux = motion_cmd;
      stepper_bus_pkg::SEL_POSITION: rd_mux = position;
      stepper_bus_pkg::SEL_SPI:      rd_mux = spi_rx;
      // bit 1 enable, bit 0 busy
      stepper_bus_pkg::SEL_STATUS:   rd_mux = {30'd0, motion_cmd.enable, spi_busy};
      default:                       rd_mux = 32'd0;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else if (acc_valid) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  // payload, held until the next access
  always_ff @(posedge clk_in) begin
    if (acc_valid) begin
      rsp.rdata <= (acc_write || acc_err) ? 32'd0 : rd_mux;
      rsp.err   <= acc_err;
    end
  end

  // stall decode while the response waits
  assign rsp_full = rsp_valid && !rsp_ready;

endmodule

`default_nettype wire

// ==== src/stepper_io.sv ====
/*
 * Memory-mapped IO block of the stepper controller. One response per accepted
 * request, in order, from the edge after acceptance. SPI runs in mode 3.
 */
`default_nettype none

module stepper_io (
  input  wire logic                      clk_in,
  input  wire logic                      rst,
  input  wire logic                      req_valid,
  input  wire stepper_bus_pkg::io_req_t  req,
  output logic                           req_ready,
  output logic                           rsp_valid,
  output stepper_bus_pkg::io_rsp_t       rsp,
  input  wire logic                      rsp_ready,
  output logic [7:0]                     led,
  output logic                           step,
  output logic                           dir_out,
  output logic                           sck,
  output logic                           mosi,
  output logic                           cs_n,
  input  wire logic                      miso
);

  // decode to execute
  logic                               motion_we;
  logic                               spi_start;
  motor_pkg::cmd_word_u               cmd;
  // decode to readback
  logic                               acc_valid;
  stepper_bus_pkg::reg_sel_t          acc_sel;
  logic                               acc_write;
  logic                               acc_err;
  logic                               rsp_full;
  // execute state for reads
  motor_pkg::motion_cmd_t             motion_cmd;
  logic signed [motor_pkg::POS_W-1:0] position;
  logic                               spi_busy;
  logic [31:0]                        spi_rx;

  io_decode u_decode (
    .clk_in    (clk_in),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rsp_full  (rsp_full),
    .spi_busy  (spi_busy),
    .led       (led),
    .motion_we (motion_we),
    .spi_start (spi_start),
    .cmd       (cmd),
    .acc_valid (acc_valid),
    .acc_sel   (acc_sel),
    .acc_write (acc_write),
    .acc_err   (acc_err)
  );

  step_generator u_step (
    .clk_in     (clk_in),
    .rst        (rst),
    .motion_we  (motion_we),
    .cmd        (cmd),
    .motion_cmd (motion_cmd),
    .step       (step),
    .dir_out    (dir_out),
    .position   (position)
  );

  driver_spi u_spi (
    .clk_in    (clk_in),
    .rst       (rst),
    .spi_start (spi_start),
    .cmd       (cmd),
    .miso      (miso),
    .sck       (sck),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .spi_busy  (spi_busy),
    .spi_rx    (spi_rx)
  );

  io_readback u_readback (
    .clk_in     (clk_in),
    .rst        (rst),
    .acc_valid  (acc_valid),
    .acc_sel    (acc_sel),
    .acc_write  (acc_write),
    .acc_err    (acc_err),
    .led        (led),
    .motion_cmd (motion_cmd),
    .position   (position),
    .spi_busy   (spi_busy),
    .spi_rx     (spi_rx),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_ready  (rsp_ready),
    .rsp_full   (rsp_full)
  );

endmodule

`default_nettype wire
